//--- src/rvc_cfg.svh
`ifndef RVC_CFG_SVH
`define RVC_CFG_SVH

// instruction widths
`define RVC_ILEN 32
`define RVC_CLEN 16

// base RV32I major opcodes
`define RVC_OPC_LOAD   7'b0000011
`define RVC_OPC_STORE  7'b0100011
`define RVC_OPC_OP_IMM 7'b0010011
`define RVC_OPC_OP     7'b0110011
`define RVC_OPC_LUI    7'b0110111
`define RVC_OPC_JAL    7'b1101111
`define RVC_OPC_JALR   7'b1100111
`define RVC_OPC_BRANCH 7'b1100011

// fixed registers used by the expansions
`define RVC_REG_ZERO 5'd0
`define RVC_REG_RA   5'd1 // link register
`define RVC_REG_SP   5'd2 // stack pointer

// addi x0, x0, 0
`define RVC_NOP    32'h00000013
`define RVC_EBREAK 32'h00100073

`endif

//--- src/rvc_pkg.sv
`include "rvc_cfg.svh"

package rvc_pkg;

    // full 32-bit instruction word
    typedef logic [`RVC_ILEN-1:0] inst_t;

    // compressed halfword, low bits != 11
    typedef logic [`RVC_CLEN-1:0] cinst_t;

    // architectural register number x0..x31
    typedef logic [4:0] reg_idx_t;

    // rd'/rs1'/rs2' field, names x8..x15
    typedef logic [2:0] creg_t;

    typedef logic [2:0] funct3_t; // funct3 in both formats

endpackage

//--- src/rvc_q0_expand.sv
`include "rvc_cfg.svh"

module rvc_q0_expand (
    input  rvc_pkg::cinst_t cinst_i,
    output rvc_pkg::inst_t  inst_o
);
    import rvc_pkg::*;

    funct3_t     funct3;
    creg_t       rs1_c;
    creg_t       rd_c;
    reg_idx_t    rs1;
    reg_idx_t    rd;        // also rs2 for c.sw
    logic [11:0] addi4spn_imm;
    logic [11:0] mem_imm;

    assign funct3 = cinst_i[15:13];
    assign rs1_c  = cinst_i[9:7];
    assign rd_c   = cinst_i[4:2];

    // compressed fields address x8..x15
    assign rs1 = {2'b01, rs1_c};
    assign rd  = {2'b01, rd_c};

    // nzuimm[9:6|5:4|3|2], scaled by 4
    assign addi4spn_imm = {2'b00, cinst_i[10:7], cinst_i[12:11],
                           cinst_i[5], cinst_i[6], 2'b00};

    // word offset[6|5:3|2]
    assign mem_imm = {5'b00000, cinst_i[5], cinst_i[12:10], cinst_i[6], 2'b00};

    always_comb begin
        case (funct3)
            3'b000: begin // c.addi4spn -> addi rd', sp, nzuimm
                inst_o = {addi4spn_imm, `RVC_REG_SP, 3'b000, rd, `RVC_OPC_OP_IMM};
            end
            3'b010: begin // c.lw -> lw rd', off(rs1')
                inst_o = {mem_imm, rs1, 3'b010, rd, `RVC_OPC_LOAD};
            end
            3'b110: begin // c.sw -> sw rs2', off(rs1')
                inst_o = {mem_imm[11:5], rd, rs1, 3'b010, mem_imm[4:0], `RVC_OPC_STORE};
            end
            default: begin
                inst_o = `RVC_NOP; // fp and reserved slots
            end
        endcase
    end

endmodule

//--- src/rvc_q1_expand.sv
`include "rvc_cfg.svh"

module rvc_q1_expand (
    input  rvc_pkg::cinst_t cinst_i,
    output rvc_pkg::inst_t  inst_o
);
    import rvc_pkg::*;

    funct3_t     funct3;
    reg_idx_t    rd;         // full rd/rs1 field
    creg_t       rs1_c;
    creg_t       rs2_c;
    reg_idx_t    rs1p;
    reg_idx_t    rs2p;
    logic        rd_is_sp;
    logic [11:0] imm6_sext;
    logic [19:0] lui_imm;
    logic [11:0] addi16sp_imm;
    logic [11:0] j_off;
    logic [20:0] j_imm;
    logic [8:0]  b_off;
    logic [12:0] b_imm;
    funct3_t     alu_f3;
    logic [6:0]  alu_f7;
    inst_t       jump_word;

    assign funct3 = cinst_i[15:13];
    assign rd     = cinst_i[11:7];
    assign rs1_c  = cinst_i[9:7];
    assign rs2_c  = cinst_i[4:2];
    assign rs1p   = {2'b01, rs1_c};
    assign rs2p   = {2'b01, rs2_c};

    assign rd_is_sp = (rd == `RVC_REG_SP);

    // shared by c.addi, c.li, c.andi
    assign imm6_sext = {{6{cinst_i[12]}}, cinst_i[12], cinst_i[6:2]};

    // nzimm[17:12] lands in the upper immediate
    assign lui_imm = {{14{cinst_i[12]}}, cinst_i[12], cinst_i[6:2]};

    // nzimm[9|8:7|6|5|4], multiple of 16
    assign addi16sp_imm = {{3{cinst_i[12]}}, cinst_i[4:3], cinst_i[5],
                           cinst_i[2], cinst_i[6], 4'b0000};

    // offset[11|10|9:8|7|6|5|4|3:1]
    assign j_off = {cinst_i[12], cinst_i[8], cinst_i[10:9], cinst_i[6], cinst_i[7],
                    cinst_i[2], cinst_i[11], cinst_i[5:3], 1'b0};
    assign j_imm = {{9{j_off[11]}}, j_off};

    // offset[8|7:6|5|4:3|2:1]
    assign b_off = {cinst_i[12], cinst_i[6:5], cinst_i[2], cinst_i[11:10],
                    cinst_i[4:3], 1'b0};
    assign b_imm = {{4{b_off[8]}}, b_off};

    // c.jal links through ra, c.j discards the link
    assign jump_word = {j_imm[20], j_imm[10:1], j_imm[11], j_imm[19:12],
                        funct3[2] ? `RVC_REG_ZERO : `RVC_REG_RA, `RVC_OPC_JAL};

    // register alu group, bits 6:5
    always_comb begin
        case (cinst_i[6:5])
            2'b00:   alu_f3 = 3'b000; // sub
            2'b01:   alu_f3 = 3'b100; // xor
            2'b10:   alu_f3 = 3'b110; // or
            default: alu_f3 = 3'b111; // and
        endcase
    end

    assign alu_f7 = (cinst_i[6:5] == 2'b00) ? 7'b0100000 : 7'b0000000;

    always_comb begin
        inst_o = `RVC_NOP;
        case (funct3)
            3'b000: begin // c.addi
                inst_o = {imm6_sext, rd, 3'b000, rd, `RVC_OPC_OP_IMM};
            end
            3'b001, 3'b101: begin // c.jal / c.j
                inst_o = jump_word;
            end
            3'b010: begin // c.li -> addi rd, x0, imm
                inst_o = {imm6_sext, `RVC_REG_ZERO, 3'b000, rd, `RVC_OPC_OP_IMM};
            end
            3'b011: begin
                if (rd_is_sp) begin // c.addi16sp
                    inst_o = {addi16sp_imm, `RVC_REG_SP, 3'b000, `RVC_REG_SP,
                              `RVC_OPC_OP_IMM};
                end else begin // c.lui
                    inst_o = {lui_imm, rd, `RVC_OPC_LUI};
                end
            end
            3'b100: begin
                case (cinst_i[11:10])
                    2'b00: begin // c.srli
                        inst_o = {7'b0000000, cinst_i[6:2], rs1p, 3'b101, rs1p,
                                  `RVC_OPC_OP_IMM};
                    end
                    2'b01: begin // c.srai
                        inst_o = {7'b0100000, cinst_i[6:2], rs1p, 3'b101, rs1p,
                                  `RVC_OPC_OP_IMM};
                    end
                    2'b10: begin // c.andi
                        inst_o = {imm6_sext, rs1p, 3'b111, rs1p, `RVC_OPC_OP_IMM};
                    end
                    default: begin
                        // bit 12 set is the rv64 subw/addw space
                        if (!cinst_i[12]) begin
                            inst_o = {alu_f7, rs2p, rs1p, alu_f3, rs1p, `RVC_OPC_OP};
                        end
                    end
                endcase
            end
            default: begin // c.beqz / c.bnez against x0
                inst_o = {b_imm[12], b_imm[10:5], `RVC_REG_ZERO, rs1p,
                          {2'b00, funct3[0]}, b_imm[4:1], b_imm[11], `RVC_OPC_BRANCH};
            end
        endcase
    end

endmodule

//--- src/rvc_q2_expand.sv
`include "rvc_cfg.svh"

module rvc_q2_expand (
    input  rvc_pkg::cinst_t cinst_i,
    output rvc_pkg::inst_t  inst_o
);
    import rvc_pkg::*;

    funct3_t     funct3;
    reg_idx_t    rd;        // rd / rs1
    reg_idx_t    rs2;
    logic        rd_zero;
    logic        rs2_zero;
    logic [11:0] lwsp_imm;
    logic [11:0] swsp_imm;

    assign funct3   = cinst_i[15:13];
    assign rd       = cinst_i[11:7];
    assign rs2      = cinst_i[6:2];
    assign rd_zero  = (rd == `RVC_REG_ZERO);
    assign rs2_zero = (rs2 == `RVC_REG_ZERO);

    // offset[7:6|5|4:2], zero extended
    assign lwsp_imm = {4'b0000, cinst_i[3:2], cinst_i[12], cinst_i[6:4], 2'b00};

    // offset[7:6|5:2]
    assign swsp_imm = {4'b0000, cinst_i[8:7], cinst_i[12:9], 2'b00};

    always_comb begin
        case (funct3)
            3'b000: begin // c.slli
                inst_o = {7'b0000000, cinst_i[6:2], rd, 3'b001, rd, `RVC_OPC_OP_IMM};
            end
            3'b010: begin // c.lwsp -> lw rd, off(sp)
                inst_o = {lwsp_imm, `RVC_REG_SP, 3'b010, rd, `RVC_OPC_LOAD};
            end
            3'b100: begin
                if (!cinst_i[12]) begin
                    if (rs2_zero) begin
                        // c.jr -> jalr x0, 0(rs1)
                        inst_o = {12'h000, rd, 3'b000, `RVC_REG_ZERO, `RVC_OPC_JALR};
                    end else begin
                        // c.mv -> add rd, x0, rs2
                        inst_o = {7'b0000000, rs2, `RVC_REG_ZERO, 3'b000, rd,
                                  `RVC_OPC_OP};
                    end
                end else if (rs2_zero) begin
                    if (rd_zero) begin
                        inst_o = `RVC_EBREAK;
                    end else begin
                        // c.jalr -> jalr ra, 0(rs1)
                        inst_o = {12'h000, rd, 3'b000, `RVC_REG_RA, `RVC_OPC_JALR};
                    end
                end else begin
                    inst_o = {7'b0000000, rs2, rd, 3'b000, rd, `RVC_OPC_OP}; // c.add
                end
            end
            3'b110: begin // c.swsp -> sw rs2, off(sp)
                inst_o = {swsp_imm[11:5], rs2, `RVC_REG_SP, 3'b010, swsp_imm[4:0],
                          `RVC_OPC_STORE};
            end
            default: begin
                inst_o = `RVC_NOP;
            end
        endcase
    end

endmodule

//--- src/rvc_expander.sv
`include "rvc_cfg.svh"

module rvc_expander (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 fetch_valid_i,
    input  logic [`RVC_ILEN-1:0] fetch_inst_i,
    output logic                 dec_valid_o,
    output logic                 dec_compressed_o,
    output logic [`RVC_ILEN-1:0] dec_inst_o
);
    import rvc_pkg::*;

    cinst_t half;          // low halfword of the fetched word
    inst_t  q0_inst;
    inst_t  q1_inst;
    inst_t  q2_inst;
    inst_t  exp_inst;
    logic   is_compressed;

    assign half          = fetch_inst_i[`RVC_CLEN-1:0];
    assign is_compressed = (fetch_inst_i[1:0] != 2'b11);

    rvc_q0_expand u_q0 (
        .cinst_i (half),
        .inst_o  (q0_inst)
    );

    rvc_q1_expand u_q1 (
        .cinst_i (half),
        .inst_o  (q1_inst)
    );

    rvc_q2_expand u_q2 (
        .cinst_i (half),
        .inst_o  (q2_inst)
    );

    // quadrant select, 11 is a full-width word
    always_comb begin
        case (fetch_inst_i[1:0])
            2'b00:   exp_inst = q0_inst;
            2'b01:   exp_inst = q1_inst;
            2'b10:   exp_inst = q2_inst;
            default: exp_inst = fetch_inst_i;
        endcase
    end

    // single output stage, word and flag hold across bubbles
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o      <= 1'b0;
            dec_compressed_o <= 1'b0;
            dec_inst_o       <= `RVC_NOP;
        end else begin
            dec_valid_o <= fetch_valid_i;
            if (fetch_valid_i) begin
                dec_inst_o       <= exp_inst;
                dec_compressed_o <= is_compressed;
            end
        end
    end

endmodule

//--- test/tb_rvc_expander.sv
`include "rvc_cfg.svh"

module tb_rvc_expander;
    import rvc_pkg::*;

    logic  clk_i;
    logic  rst_n_i;
    logic  fetch_valid_i;
    inst_t fetch_inst_i;
    logic  dec_valid_o;
    logic  dec_compressed_o;
    inst_t dec_inst_o;

    // case table with one entry per line of test/rvc_cases.txt
    string case_name[$];
    inst_t case_in[$];
    inst_t case_exp[$];
    logic  case_flag[$];

    integer seed;
    int     cycle_count;
    int     cycle_limit;
    int     check_count;
    int     error_count;
    int     test_count;
    int     failed_tests;
    bit     load_failed;

    rvc_expander uut (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_inst_i     (fetch_inst_i),
        .dec_valid_o      (dec_valid_o),
        .dec_compressed_o (dec_compressed_o),
        .dec_inst_o       (dec_inst_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // watchdog armed once the case count is known
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk_i);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: run still busy after %0d cycles", cycle_count);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic compare_value(input string test_name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        check_count = check_count + 1;
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("ERROR %s %s: expected %h, actual %h",
                     test_name, field, expected, actual);
        end
    endtask

    task automatic report_test(input string test_name, input int mismatches);
        test_count = test_count + 1;
        if (mismatches == 0) begin
            $display("test %s ok", test_name);
        end else begin
            failed_tests = failed_tests + 1;
            $display("test %s failed with %0d mismatches", test_name, mismatches);
        end
    endtask

    task automatic load_cases();
        int               fd;
        int               n;
        string            tok;
        logic [8*160-1:0] skip_line;
        inst_t            in_word;
        inst_t            exp_word;
        logic [3:0]       flag;
        fd = $fopen("test/rvc_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/rvc_cases.txt");
            load_failed = 1'b1;
        end else begin
            while (!$feof(fd) && !load_failed) begin
                tok = "";
                n = $fscanf(fd, "%s", tok);
                if (n == 1 && tok.len() > 0) begin
                    if (tok.getc(0) == "#") begin
                        n = $fgets(skip_line, fd); // rest of a comment line
                    end else begin
                        n = $fscanf(fd, "%h %h %h", in_word, exp_word, flag);
                        if (n == 3) begin
                            case_name.push_back(tok);
                            case_in.push_back(in_word);
                            case_exp.push_back(exp_word);
                            case_flag.push_back(flag[0]);
                        end else begin
                            $display("case %s has a malformed line in the case file", tok);
                            load_failed = 1'b1;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        int errors_before;
        errors_before = error_count;
        rst_n_i = 1'b0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i); // one idle edge out of reset
        compare_value("reset", "valid", 32'd0, {31'd0, dec_valid_o});
        compare_value("reset", "inst", `RVC_NOP, dec_inst_o);
        compare_value("reset", "compressed", 32'd0, {31'd0, dec_compressed_o});
        report_test("reset", error_count - errors_before);
    endtask

    // one case followed by 0..2 idle cycles
    task automatic run_case(input int idx);
        int    errors_before;
        int    bubbles;
        string idle_name;
        errors_before = error_count;
        fetch_valid_i = 1'b1;
        fetch_inst_i  = case_in[idx];
        @(negedge clk_i);
        compare_value(case_name[idx], "valid", 32'd1, {31'd0, dec_valid_o});
        compare_value(case_name[idx], "inst", case_exp[idx], dec_inst_o);
        compare_value(case_name[idx], "compressed", {31'd0, case_flag[idx]},
                      {31'd0, dec_compressed_o});
        bubbles   = $unsigned($random(seed)) % 3;
        idle_name = {case_name[idx], "/idle"};
        repeat (bubbles) begin
            fetch_valid_i = 1'b0;
            fetch_inst_i  = $random(seed); // junk that must not reach the output
            @(negedge clk_i);
            compare_value(idle_name, "valid", 32'd0, {31'd0, dec_valid_o});
            compare_value(idle_name, "inst", case_exp[idx], dec_inst_o);
            compare_value(idle_name, "compressed", {31'd0, case_flag[idx]},
                          {31'd0, dec_compressed_o});
        end
        report_test(case_name[idx], error_count - errors_before);
    endtask

    task automatic drain_check(input int last);
        int errors_before;
        errors_before = error_count;
        fetch_valid_i = 1'b0;
        fetch_inst_i  = 32'h0000_0000;
        @(negedge clk_i);
        compare_value("drain", "valid", 32'd0, {31'd0, dec_valid_o});
        compare_value("drain", "inst", case_exp[last], dec_inst_o);
        compare_value("drain", "compressed", {31'd0, case_flag[last]},
                      {31'd0, dec_compressed_o});
        report_test("drain", error_count - errors_before);
    endtask

    initial begin
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_inst_i  = 32'h0000_0000;
        seed          = 71;
        cycle_count   = 0;
        cycle_limit   = 0;
        check_count   = 0;
        error_count   = 0;
        test_count    = 0;
        failed_tests  = 0;
        load_failed   = 1'b0;
        load_cases();
        if (load_failed || case_name.size() == 0) begin
            $display("no usable test cases, run aborted");
            $display("=== FAIL ===");
        end else begin
            cycle_limit = 4 * case_name.size() + 20;
            apply_reset();
            for (int i = 0; i < case_name.size(); i++) begin
                run_case(i);
            end
            drain_check(case_name.size() - 1);
            $display("%0d tests, %0d failed, %0d checks, %0d mismatches",
                     test_count, failed_tests, check_count, error_count);
            if (error_count == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+src
src/rvc_pkg.sv
src/rvc_q0_expand.sv
src/rvc_q1_expand.sv
src/rvc_q2_expand.sv
src/rvc_expander.sv
test/tb_rvc_expander.sv

//--- test/rvc_cases.txt
# columns: name, input word, expected word, compressed flag (all hex)
# low bits 11 pass through unchanged with flag 0
q0_addi4spn   ABCD0244 10410493 1
q0_lw         000041E8 0445A503 1
q0_sw         0000DC7C 06F42E23 1
q0_rsvd_f001  00002000 00000013 1
q0_rsvd_f111  0000E000 00000013 1
q1_addi_pos   FFFF0505 00150513 1
q1_addi_neg   000012F5 FFD28293 1
q1_jal        00002E91 354000EF 1
q1_li_neg     00005501 FE000513 1
q1_lui_pos    000067FD 0001F7B7 1
q1_lui_neg    00007181 FFFE01B7 1
q1_addi16sp   00007139 FC010113 1
q1_srli       0000809D 0074D493 1
q1_srai       0000877D 41F75713 1
q1_andi       00009A61 FF867613 1
q1_sub        00008C05 40940433 1
q1_xor        00008D2D 00B54533 1
q1_or         00008ED9 00E6E6B3 1
q1_and        00008FE1 0087F7B3 1
q1_j_neg      0000BFC5 FF1FF06F 1
q1_beqz_neg   0000DCED FE048DE3 1
q1_bnez_pos   0000E7CD 0A079563 1
q1_rsvd_subw  00009C05 00000013 1
q2_slli       00000A32 00CA1A13 1
q2_lwsp       0000537E 0FC12303 1
q2_jr         00008082 00008067 1
q2_mv         0000852E 00B00533 1
q2_ebreak     00009002 00100073 1
q2_jalr       00009282 000280E7 1
q2_add        00009426 00940433 1
q2_swsp       0000C5FE 0DF12423 1
q2_rsvd_f001  00002002 00000013 1
q2_rsvd_f111  0000E002 00000013 1
full_add      00A50533 00A50533 0
full_word     DEADBEEF DEADBEEF 0
